/* hw/scope_pkg.sv */
// scope acquisition package
// sample, accumulator and config types shared by the channel stages
// plus the trigger comparator state encoding

package scope_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int unsigned dwi = 14;  // adc sample width
  localparam int unsigned dwc = 17;  // decimation counter width
  localparam int unsigned dws = 4;   // sum shift width
  localparam int unsigned dwg = 16;  // gain width, 14 fraction bits

  localparam int unsigned gain_one = 16384;  // unity gain in Q2.14

  ////////////////////
  // types
  ////////////////////

  // one sample anywhere in the chain
  typedef logic signed [dwi-1:0] sample_t;

  // averaging accumulator, wide enough for 2**dwc samples
  typedef logic signed [dwi+dwc-1:0] sum_t;

  typedef logic [dwc-1:0] dec_t;   // decimation factor minus one
  typedef logic [dws-1:0] shr_t;   // right shift on the group sum
  typedef logic [dwg-1:0] gain_t;  // unsigned fixed point gain

  // hysteresis comparator state
  typedef enum logic [1:0] {
    st_unknown,  // nothing seen yet, no trigger allowed
    st_low,      // last decision was below the band
    st_high      // last decision was at or above level
  } trig_state_t;

endpackage

/* hw/scope_calib.sv */
// scope calibration stage
// adds a signed offset, scales by an unsigned Q2.14 gain
// and clamps the result to the sample range, registered output

`timescale 1ns/100ps

module scope_calib (
  input  logic               clk,       // clock
  input  logic               rstn,      // sync reset, active low
  // configuration
  input  scope_pkg::sample_t cfg_off,   // offset added before the gain
  input  scope_pkg::gain_t   cfg_gain,  // gain, 16384 is unity
  // stream input
  input  scope_pkg::sample_t sti_dat,
  input  logic               sti_vld,
  output logic               sti_rdy,
  // stream output
  output scope_pkg::sample_t sto_dat,
  output logic               sto_vld,
  input  logic               sto_rdy
);

  import scope_pkg::*;

  logic                      sti_trn;   // input transfer this cycle
  logic signed [dwi:0]       off_sum;   // sample plus offset, one guard bit
  logic signed [dwg:0]       gain_s;    // gain as a positive signed value
  logic signed [dwi+dwg+1:0] prod;      // full product
  logic signed [dwi+dwg+1:0] prod_shr;  // product back in sample scale
  logic        [dwg+2:0]     prod_hi;   // bits that must match the sign
  sample_t                   cal_sat;   // clamped result

  ////////////////////
  // handshake
  ////////////////////

  // take a sample when the register is empty or drains now
  assign sti_rdy = sto_rdy | ~sto_vld;
  assign sti_trn = sti_vld & sti_rdy;

  ////////////////////
  // arithmetic
  ////////////////////

  assign off_sum = (dwi+1)'(sti_dat) + (dwi+1)'(cfg_off);
  assign gain_s  = {1'b0, cfg_gain};  // zero extend, gain is unsigned
  assign prod    = (dwi+dwg+2)'(off_sum) * (dwi+dwg+2)'(gain_s);

  // arithmetic shift rounds toward minus infinity
  assign prod_shr = prod >>> $clog2(gain_one);
  assign prod_hi  = prod_shr[dwi+dwg+1:dwi-1];

  always_comb begin
    if (&prod_hi || ~|prod_hi) begin
      cal_sat = prod_shr[dwi-1:0];  // fits, plain truncation
    end else if (prod_shr[dwi+dwg+1]) begin
      cal_sat = {1'b1, {(dwi-1){1'b0}}};  // clamp to most negative
    end else begin
      cal_sat = {1'b0, {(dwi-1){1'b1}}};  // clamp to most positive
    end
  end

  ////////////////////
  // output register
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sto_vld <= 1'b0;
    end else if (sti_trn) begin
      sto_vld <= 1'b1;
    end else if (sto_rdy) begin
      sto_vld <= 1'b0;  // held sample left, nothing new
    end
  end

  always_ff @(posedge clk) begin
    if (sti_trn) sto_dat <= cal_sat;
  end

  // held output must not change before it is taken
  a_dat_stable: assert property (@(posedge clk) disable iff (!rstn)
    sto_vld && !sto_rdy |=> $stable(sto_dat));

endmodule

/* hw/scope_dec_avg.sv */
// scope decimation stage
// keeps the last sample of every cfg_dec+1 samples, or sums the group,
// shifts the sum right and clamps it to the sample range

`timescale 1ns/100ps

module scope_dec_avg (
  input  logic               clk,      // clock
  input  logic               rstn,     // sync reset, active low
  input  logic               ctl_clr,  // sync clear of grouping state
  // configuration
  input  logic               cfg_avg,  // 1 average, 0 plain decimation
  input  scope_pkg::dec_t    cfg_dec,  // group length minus one
  input  scope_pkg::shr_t    cfg_shr,  // right shift on the group sum
  // stream input
  input  scope_pkg::sample_t sti_dat,
  input  logic               sti_vld,
  output logic               sti_rdy,
  // stream output
  output scope_pkg::sample_t sto_dat,
  output logic               sto_vld,
  input  logic               sto_rdy
);

  import scope_pkg::*;

  logic              sti_trn;  // input transfer
  logic              last;     // current sample closes the group
  logic              emit;     // write the output register this cycle
  dec_t              cnt;      // position inside the group
  sum_t              sum;      // running group sum
  sum_t              sum_nxt;  // sum including the current sample
  sum_t              avg_shr;  // scaled group sum
  logic [dwc:0]      avg_hi;   // bits that must match the sign
  sample_t           avg_sat;  // clamped average

  ////////////////////
  // handshake
  ////////////////////

  assign sti_rdy = sto_rdy | ~sto_vld;
  assign sti_trn = sti_vld & sti_rdy;

  assign last = (cnt == cfg_dec);
  assign emit = sti_trn & last & ~ctl_clr;  // a sample taken under clear is dropped

  ////////////////////
  // counter and accumulator
  ////////////////////

  // first sample of a group loads, later ones add
  assign sum_nxt = (cnt == '0) ? sum_t'(sti_dat) : sum + sum_t'(sti_dat);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt <= '0;
      sum <= '0;
    end else if (ctl_clr) begin
      cnt <= '0;  // next sample starts a new group
      sum <= '0;
    end else if (sti_trn) begin
      sum <= sum_nxt;
      if (last) cnt <= '0;
      else      cnt <= cnt + 1'b1;
    end
  end

  ////////////////////
  // scaling and saturation
  ////////////////////

  assign avg_shr = sum_nxt >>> cfg_shr;  // full group sum incl. last sample
  assign avg_hi  = avg_shr[dwi+dwc-1:dwi-1];

  always_comb begin
    if (&avg_hi || ~|avg_hi) begin
      avg_sat = avg_shr[dwi-1:0];
    end else if (avg_shr[dwi+dwc-1]) begin
      avg_sat = {1'b1, {(dwi-1){1'b0}}};  // negative overflow
    end else begin
      avg_sat = {1'b0, {(dwi-1){1'b1}}};  // positive overflow
    end
  end

  ////////////////////
  // output register
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sto_vld <= 1'b0;
    end else if (emit) begin
      sto_vld <= 1'b1;
    end else if (sto_rdy) begin
      sto_vld <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (emit) sto_dat <= cfg_avg ? avg_sat : sti_dat;
  end

  // counter stays inside the group, config is static
  a_cnt_range: assert property (@(posedge clk) disable iff (!rstn)
    cnt <= cfg_dec);

  // a pending output waits for the consumer
  a_vld_hold: assert property (@(posedge clk) disable iff (!rstn)
    sto_vld && !sto_rdy |=> sto_vld);

endmodule

/* hw/scope_edge_trig.sv */
// scope edge trigger stage
// hysteresis comparator against cfg_lvl, tags the sample that causes
// the selected low to high or high to low move, data passes unchanged

`timescale 1ns/100ps

module scope_edge_trig (
  input  logic               clk,      // clock
  input  logic               rstn,     // sync reset, active low
  input  logic               ctl_clr,  // sync clear of comparator state
  // configuration
  input  scope_pkg::sample_t cfg_lvl,  // threshold
  input  scope_pkg::sample_t cfg_hys,  // hysteresis, non-negative
  input  logic               cfg_neg,  // 1 falling edge, 0 rising edge
  // stream input
  input  scope_pkg::sample_t sti_dat,
  input  logic               sti_vld,
  output logic               sti_rdy,
  // stream output
  output scope_pkg::sample_t sto_dat,
  output logic               sto_trg,  // trigger tag on this sample
  output logic               sto_vld,
  input  logic               sto_rdy
);

  import scope_pkg::*;

  logic                sti_trn;  // input transfer
  logic signed [dwi:0] thr_lo;   // lower band edge, guard bit for overflow
  logic                above;    // at or above level
  logic                below;    // under the band
  logic                trg;      // selected edge on current sample
  trig_state_t         st;       // comparator state
  trig_state_t         st_nxt;

  ////////////////////
  // handshake
  ////////////////////

  assign sti_rdy = sto_rdy | ~sto_vld;
  assign sti_trn = sti_vld & sti_rdy;

  ////////////////////
  // comparator
  ////////////////////

  assign thr_lo = (dwi+1)'(cfg_lvl) - (dwi+1)'(cfg_hys);
  assign above  = (sti_dat >= cfg_lvl);
  assign below  = ((dwi+1)'(sti_dat) < thr_lo);

  // inside the band the state is kept
  always_comb begin
    st_nxt = st;
    if (above)      st_nxt = st_high;
    else if (below) st_nxt = st_low;
  end

  // leaving st_unknown never fires
  assign trg = cfg_neg ? (st == st_high && st_nxt == st_low)
                       : (st == st_low  && st_nxt == st_high);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      st <= st_unknown;
    end else if (ctl_clr) begin
      st <= st_unknown;
    end else if (sti_trn) begin
      st <= st_nxt;
    end
  end

  ////////////////////
  // output register
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sto_vld <= 1'b0;
      sto_trg <= 1'b0;
    end else if (sti_trn) begin
      sto_vld <= 1'b1;
      sto_trg <= trg & ~ctl_clr;  // no trigger out of a cleared state
    end else if (sto_rdy) begin
      sto_vld <= 1'b0;
      sto_trg <= 1'b0;  // tag goes with its sample
    end
  end

  always_ff @(posedge clk) begin
    if (sti_trn) sto_dat <= sti_dat;  // sample passes unchanged
  end

  a_trg_vld: assert property (@(posedge clk) disable iff (!rstn)
    sto_trg |-> sto_vld);

endmodule

/* hw/scope_acq_top.sv */
// scope acquisition channel top level
// calibration, decimation/averaging and edge trigger in a
// valid/ready pipeline, one output register per stage

`timescale 1ns/100ps

module scope_acq_top (
  input  logic               clk,       // clock
  input  logic               rstn,      // sync reset, active low
  input  logic               ctl_clr,   // clears grouping and trigger state
  // calibration config
  input  scope_pkg::sample_t cfg_off,
  input  scope_pkg::gain_t   cfg_gain,
  // decimation config
  input  logic               cfg_avg,
  input  scope_pkg::dec_t    cfg_dec,
  input  scope_pkg::shr_t    cfg_shr,
  // trigger config
  input  scope_pkg::sample_t cfg_lvl,
  input  scope_pkg::sample_t cfg_hys,
  input  logic               cfg_neg,
  // adc samples in
  input  scope_pkg::sample_t in_dat,
  input  logic               in_vld,
  output logic               in_rdy,
  // tagged samples out
  output scope_pkg::sample_t out_dat,
  output logic               out_trg,
  output logic               out_vld,
  input  logic               out_rdy
);

  import scope_pkg::*;

  sample_t cal_dat;  // calib -> dec_avg
  logic    cal_vld;
  logic    cal_rdy;
  sample_t dec_dat;  // dec_avg -> edge_trig
  logic    dec_vld;
  logic    dec_rdy;

  scope_calib calib (
    .clk      (clk),
    .rstn     (rstn),
    .cfg_off  (cfg_off),
    .cfg_gain (cfg_gain),
    .sti_dat  (in_dat),
    .sti_vld  (in_vld),
    .sti_rdy  (in_rdy),
    .sto_dat  (cal_dat),
    .sto_vld  (cal_vld),
    .sto_rdy  (cal_rdy)
  );

  scope_dec_avg dec_avg (
    .clk     (clk),
    .rstn    (rstn),
    .ctl_clr (ctl_clr),
    .cfg_avg (cfg_avg),
    .cfg_dec (cfg_dec),
    .cfg_shr (cfg_shr),
    .sti_dat (cal_dat),
    .sti_vld (cal_vld),
    .sti_rdy (cal_rdy),
    .sto_dat (dec_dat),
    .sto_vld (dec_vld),
    .sto_rdy (dec_rdy)
  );

  scope_edge_trig edge_trig (
    .clk     (clk),
    .rstn    (rstn),
    .ctl_clr (ctl_clr),
    .cfg_lvl (cfg_lvl),
    .cfg_hys (cfg_hys),
    .cfg_neg (cfg_neg),
    .sti_dat (dec_dat),
    .sti_vld (dec_vld),
    .sti_rdy (dec_rdy),
    .sto_dat (out_dat),
    .sto_trg (out_trg),
    .sto_vld (out_vld),
    .sto_rdy (out_rdy)
  );

endmodule

/* tests/scope_tb_clk.sv */
// testbench clock and reset source
// 4 ns clock, reset held low for the first 8 rising edges

`timescale 1ns/100ps

module scope_tb_clk (
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  initial begin
    rstn = 1'b0;
    repeat (8) @(posedge clk);
    #1;  // release off the edge, like all other stimulus
    rstn = 1'b1;
  end

endmodule

/* tests/scope_acq_tb.sv */
// scope acquisition channel testbench
// reference model on accepted inputs feeds an expected queue
// and a concurrent assertion checks every output transfer against its head

`timescale 1ns/100ps

module scope_acq_tb;

  import scope_pkg::*;

  localparam int     frac     = 14;                               // gain fraction bits
  localparam longint smax     = (longint'(1) <<< (dwi - 1)) - 1;  // sample range
  localparam longint smin     = -(longint'(1) <<< (dwi - 1));
  localparam int     wait_lim = 2000;                             // cycles per wait

  logic        clk;
  logic        rstn;
  logic        ctl_clr;
  sample_t     cfg_off;
  gain_t       cfg_gain;
  logic        cfg_avg;
  dec_t        cfg_dec;
  shr_t        cfg_shr;
  sample_t     cfg_lvl;
  sample_t     cfg_hys;
  logic        cfg_neg;
  sample_t     in_dat;
  logic        in_vld;
  logic        in_rdy;
  sample_t     out_dat;
  logic        out_trg;
  logic        out_vld;
  logic        out_rdy;

  logic [dwi:0] exp_q[$];  // {trg, dat} in output order
  int           m_cnt;     // model group position
  longint       m_sum;     // model group sum
  trig_state_t  m_st;      // model comparator state
  logic         head_vld;  // queue head as of the last rising edge
  sample_t      head_dat;
  logic         head_trg;
  int           out_seen;  // output transfers so far
  int           trg_seen;  // tagged outputs so far
  int           mism_cnt;  // failed output compares
  int           err_cnt;   // other failed checks
  int           test_cnt;
  int           fail_cnt;
  int           err_mark;
  int           out_mark;
  int           trg_mark;
  bit           rdy_rand;  // random out_rdy when set
  string        cur_name;

  scope_tb_clk clkgen (.clk(clk), .rstn(rstn));

  scope_acq_top uut (.*);

  ////////////////////
  // reference model
  ////////////////////

  function automatic sample_t clamp(input longint v);
    if (v > smax) return sample_t'(smax);
    if (v < smin) return sample_t'(smin);
    return sample_t'(v);
  endfunction

  // one accepted input through calib, grouping and trigger
  function automatic void model_input(input sample_t x);
    sample_t     cal;
    sample_t     res;
    trig_state_t nxt;
    logic        trg;
    cal = clamp(((longint'(x) + longint'(cfg_off)) * longint'(cfg_gain)) >>> frac);
    if (m_cnt == 0) m_sum = longint'(cal);  // group opens
    else            m_sum = m_sum + longint'(cal);
    if (m_cnt != int'(cfg_dec)) begin
      m_cnt++;
      return;
    end
    m_cnt = 0;
    res = cfg_avg ? clamp(m_sum >>> cfg_shr) : cal;
    nxt = m_st;
    if (longint'(res) >= longint'(cfg_lvl)) nxt = st_high;
    else if (longint'(res) < longint'(cfg_lvl) - longint'(cfg_hys)) nxt = st_low;
    trg = cfg_neg ? (m_st == st_high && nxt == st_low) : (m_st == st_low && nxt == st_high);
    m_st = nxt;
    exp_q.push_back({trg, res});
  endfunction

  // handshakes sampled mid-cycle where everything is settled
  always @(negedge clk) begin
    if (!rstn) begin
      m_cnt = 0;
      m_sum = 0;
      m_st  = st_unknown;
      exp_q.delete();
    end else begin
      if (out_vld && out_rdy) begin
        out_seen++;
        if (out_trg) trg_seen++;
        if (exp_q.size() != 0) exp_q.delete(0);  // consumed
      end
      if (ctl_clr) begin
        m_cnt = 0;
        m_st  = st_unknown;
      end
      if (in_vld && in_rdy) model_input(in_dat);
    end
  end

  always @(posedge clk) begin
    if (exp_q.size() != 0) begin
      head_vld <= 1'b1;
      {head_trg, head_dat} <= exp_q[0];
    end else begin
      head_vld <= 1'b0;
    end
  end

  // every output transfer must match the next expected pair
  a_out_match: assert property (@(negedge clk) disable iff (!rstn)
    (out_vld && out_rdy) |-> (head_vld && out_dat == head_dat && out_trg == head_trg))
  else begin
    mism_cnt++;
    if (!head_vld) begin
      $display("output transfer at %0t with no sample expected", $time);
    end else begin
      if (out_dat != head_dat)
        $display("error at %0t: out_dat expected %0d got %0d", $time, head_dat, out_dat);
      if (out_trg != head_trg)
        $display("error at %0t: out_trg expected %b got %b", $time, head_trg, out_trg);
    end
  end

  ////////////////////
  // stimulus helpers
  ////////////////////

  task automatic report_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    err_cnt++;
  endtask

  // one valid/ready transfer started at edge + 1 ns
  task automatic send(input sample_t d);
    int n;
    n = 0;
    in_dat = d;
    in_vld = 1'b1;
    @(negedge clk);
    while (!in_rdy && n < wait_lim) begin
      @(negedge clk);
      n++;
    end
    if (!in_rdy) report_timeout("in_rdy");
    @(posedge clk);  // transfer edge
    #1;
    in_vld = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic ramp(input int from, input int to, input int step);
    int v;
    v = from;
    while ((step > 0) ? (v <= to) : (v >= to)) begin
      send(sample_t'(v));
      v += step;
    end
  endtask

  task automatic band_noise(input int n);  // stays inside 800..999
    repeat (n) send(sample_t'(800 + int'($urandom_range(0, 199))));
  endtask

  task automatic pulse_clear();
    ctl_clr = 1'b1;
    @(posedge clk);
    #1;
    ctl_clr = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < wait_lim) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) report_timeout("the expected queue to drain");
    repeat (4) @(posedge clk);  // partial groups settle in dec_avg
    #1;
  endtask

  task automatic expect_count(input string what, input int exp, input int got);
    assert (got == exp) else begin
      $display("error at %0t: %s expected %0d got %0d", $time, what, exp, got);
      err_cnt++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_name = name;
    err_mark = err_cnt + mism_cnt;
    out_mark = out_seen;
    trg_mark = trg_seen;
  endtask

  task automatic end_test();
    test_cnt++;
    if (err_cnt + mism_cnt != err_mark) begin
      fail_cnt++;
      $display("test %0d %s: FAILED", test_cnt, cur_name);
    end else begin
      $display("test %0d %s: ok", test_cnt, cur_name);
    end
  endtask

  ////////////////////
  // tests
  ////////////////////

  initial begin
    out_rdy = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      out_rdy = rdy_rand ? ($urandom_range(0, 2) != 0) : 1'b1;  // ~2/3 ready
    end
  end

  initial begin
    int n;
    int i;
    int r;
    ctl_clr  = 1'b0;
    cfg_off  = '0;
    cfg_gain = gain_t'(gain_one);
    cfg_avg  = 1'b0;
    cfg_dec  = '0;
    cfg_shr  = '0;
    cfg_lvl  = '0;
    cfg_hys  = '0;
    cfg_neg  = 1'b0;
    in_dat   = '0;
    in_vld   = 1'b0;
    void'($urandom(66504));
    n = 0;
    while (rstn !== 1'b1 && n < 50) begin
      @(posedge clk);
      n++;
    end
    if (rstn !== 1'b1) report_timeout("reset release");
    #1;

    begin_test("passthrough");
    assert (out_vld === 1'b0 && out_trg === 1'b0) else begin
      $display("error at %0t: out_vld,out_trg expected 0,0 got %b,%b", $time, out_vld, out_trg);
      err_cnt++;
    end
    for (i = 0; i < 40; i++) send(sample_t'($urandom));
    wait_drain();
    expect_count("output count", 40, out_seen - out_mark);
    end_test();

    begin_test("calib saturation");
    for (r = 0; r < 6; r++) begin
      cfg_off  = sample_t'($urandom);
      cfg_gain = gain_t'($urandom);
      for (i = 0; i < 24; i++) begin  // alternate both ends of the range
        if (i % 2 == 1) send(sample_t'(smax - longint'($urandom_range(0, 63))));
        else            send(sample_t'(smin + longint'($urandom_range(0, 63))));
      end
      wait_drain();
    end
    expect_count("output count", 144, out_seen - out_mark);
    cfg_off  = '0;
    cfg_gain = gain_t'(gain_one);
    end_test();

    begin_test("decimation");
    cfg_dec = dec_t'(3);
    for (i = 0; i < 16; i++) send(sample_t'($urandom));
    wait_drain();
    expect_count("output count", 4, out_seen - out_mark);
    send(sample_t'($urandom));
    send(sample_t'($urandom));
    idle(4);
    pulse_clear();  // drops the half group
    for (i = 0; i < 8; i++) send(sample_t'($urandom));
    wait_drain();
    expect_count("output count", 6, out_seen - out_mark);
    end_test();

    begin_test("averaging");
    cfg_dec = dec_t'(7);
    cfg_avg = 1'b1;
    cfg_shr = shr_t'(3);
    for (i = 0; i < 64; i++) send(sample_t'(int'($urandom_range(0, 8000)) - 4000));
    wait_drain();
    cfg_shr = '0;  // unscaled sums overflow
    for (i = 0; i < 32; i++) send(sample_t'(6000 + int'($urandom_range(0, 2191))));
    for (i = 0; i < 32; i++) send(sample_t'(-6000 - int'($urandom_range(0, 2192))));
    wait_drain();
    expect_count("output count", 16, out_seen - out_mark);
    cfg_dec = '0;
    cfg_avg = 1'b0;
    end_test();

    begin_test("edge trigger");
    cfg_lvl = sample_t'(1000);
    cfg_hys = sample_t'(200);
    for (r = 0; r < 2; r++) begin
      cfg_neg = r[0];
      pulse_clear();
      trg_mark = trg_seen;
      ramp(-2000, 3000, 250);
      band_noise(8);
      ramp(3000, -2000, -250);
      band_noise(8);
      ramp(-2000, 3000, 250);
      ramp(3000, -2000, -250);
      wait_drain();
      expect_count("trigger count", 2, trg_seen - trg_mark);  // two moves each way
    end
    end_test();

    begin_test("back-pressure");
    cfg_off  = sample_t'(100);
    cfg_gain = gain_t'(20000);
    cfg_dec  = dec_t'(1);
    cfg_avg  = 1'b1;
    cfg_shr  = shr_t'(1);
    cfg_lvl  = '0;
    cfg_hys  = sample_t'(300);
    cfg_neg  = 1'b0;
    rdy_rand = 1'b1;
    for (i = 0; i < 500; i++) begin
      if ($urandom_range(0, 3) == 0) idle(int'($urandom_range(1, 3)));
      send(sample_t'(int'($urandom_range(0, 8000)) - 4000));
    end
    rdy_rand = 1'b0;
    wait_drain();
    expect_count("output count", 250, out_seen - out_mark);
    end_test();

    $display("tests %0d, failed %0d, mismatches %0d, other errors %0d",
             test_cnt, fail_cnt, mism_cnt, err_cnt);
    if (fail_cnt == 0 && mism_cnt == 0 && err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* scope_acq_top.f */
hw/scope_pkg.sv
hw/scope_calib.sv
hw/scope_dec_avg.sv
hw/scope_edge_trig.sv
hw/scope_acq_top.sv
tests/scope_tb_clk.sv
tests/scope_acq_tb.sv

/* Makefile */
# Verilator flow for the scope acquisition channel

VERILATOR  = verilator
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -j 0
TOP        = scope_acq_tb
RTL_TOP    = scope_acq_top
FLIST      = scope_acq_top.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = All tests passed

.PHONY: all lint sim clean

all: sim

# lint the synthesizable part only
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
